// File: flist.f
source/chess_pkg.sv
source/draw_if.sv
source/draw_control.sv
source/square_walker.sv
source/board_memory.sv
source/pixel_shader.sv
source/chess_board_view.sv
tb/chess_board_view_properties.sv
tb/chess_board_view_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the chess board view testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module chess_board_view_tb \
  -f flist.f \
  -o chess_board_view_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/chess_board_view_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "TEST FAILED" "$log_file"; then
  echo "simulation reported a failure"
  exit 1
fi

echo "simulation finished without failures"
exit 0

// File: source/board_memory.sv
/* board piece memory */

`timescale 1ns/1ps

module board_memory (
  input  logic             clk,
  input  logic             wr_en,
  input  logic [2:0]       wr_x,
  input  logic [2:0]       wr_y,
  input  chess_pkg::piece_t wr_piece,
  input  logic [2:0]       rd_x,
  input  logic [2:0]       rd_y,
  output chess_pkg::piece_t rd_piece
);

  localparam int depth = chess_pkg::board_n * chess_pkg::board_n;

  chess_pkg::piece_t mem [depth];  // row * 8 + column

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[{wr_y, wr_x}] <= wr_piece;
    rd_piece <= mem[{rd_y, rd_x}];  // one cycle read
  end

endmodule

// File: source/chess_board_view.sv
/* chess board view top */

`timescale 1ns/1ps

module chess_board_view (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     start,
  input  logic                     select,
  input  logic [2:0]               cursor_x,
  input  logic [2:0]               cursor_y,
  input  logic                     wr_en,
  input  logic [2:0]               wr_x,
  input  logic [2:0]               wr_y,
  input  chess_pkg::piece_t        wr_piece,
  output logic                     plot,
  output logic [8:0]               x_out,
  output logic [7:0]               y_out,
  output chess_pkg::pixel_colour_t colour,
  output logic                     busy,
  output logic                     done
);

  draw_if dif ();

  logic [8:0]        x_pos;
  logic [7:0]        y_pos;
  chess_pkg::piece_t piece;  // entry for the square being drawn

  draw_control u_control (
    .clk    (clk),
    .resetn (resetn),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .d      (dif.ctrl)
  );

  square_walker u_walker (
    .clk    (clk),
    .resetn (resetn),
    .d      (dif.walker),
    .x_pos  (x_pos),
    .y_pos  (y_pos)
  );

  board_memory u_board (
    .clk      (clk),
    .wr_en    (wr_en),
    .wr_x     (wr_x),
    .wr_y     (wr_y),
    .wr_piece (wr_piece),
    .rd_x     (dif.view_x),
    .rd_y     (dif.view_y),
    .rd_piece (piece)
  );

  pixel_shader u_shader (
    .clk      (clk),
    .resetn   (resetn),
    .d        (dif.shade),
    .piece    (piece),
    .cursor_x (cursor_x),
    .cursor_y (cursor_y),
    .select   (select),
    .x_pos    (x_pos),
    .y_pos    (y_pos),
    .plot     (plot),
    .x_out    (x_out),
    .y_out    (y_out),
    .colour   (colour)
  );

endmodule

// File: source/chess_pkg.sv
/* chess board view definitions */

package chess_pkg;

  // board geometry, in squares and pixels
  localparam int board_n    = 8;
  localparam int square_pix = 28;
  localparam int origin_x   = 8;   // top-left corner of the board
  localparam int origin_y   = 8;
  localparam int mark_len   = 4;   // arm length of a cursor bracket

  // piece kind, low 3 bits of a board entry
  typedef enum logic [2:0] {
    none   = 3'd0,
    pawn   = 3'd1,
    knight = 3'd2,
    bishop = 3'd3,
    rook   = 3'd4,
    queen  = 3'd5,
    king   = 3'd6
  } piece_kind_t;

  // one board entry, side bit on top
  typedef struct packed {
    logic        black;  // 1 = black side
    piece_kind_t kind;
  } piece_t;

  // colour codes sent with each plotted pixel
  typedef enum logic [2:0] {
    dark_square  = 3'd0,
    light_square = 3'd1,
    white_piece  = 3'd2,
    black_piece  = 3'd3,
    marker       = 3'd4
  } pixel_colour_t;

  // frame sequencer states
  typedef enum logic [2:0] {
    idle   = 3'd0,
    load   = 3'd1,  // step to next square
    fetch  = 3'd2,  // wait for board memory read
    draw   = 3'd3,  // one pixel per cycle
    finish = 3'd4
  } draw_state_t;

endpackage

// File: source/draw_control.sv
/* frame draw sequencer */

`timescale 1ns/1ps

module draw_control (
  input  logic clk,
  input  logic resetn,
  input  logic start,
  output logic busy,
  output logic done,
  draw_if.ctrl d
);

  chess_pkg::draw_state_t state;
  chess_pkg::draw_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      chess_pkg::idle: begin
        if (start)
          state_next = chess_pkg::load;
      end
      chess_pkg::load: begin
        state_next = chess_pkg::fetch;
      end
      chess_pkg::fetch: begin
        state_next = chess_pkg::draw;  // piece is valid from here on
      end
      chess_pkg::draw: begin
        if (d.square_done) begin
          if (d.last_square)
            state_next = chess_pkg::finish;
          else
            state_next = chess_pkg::load;
        end
      end
      chess_pkg::finish: begin
        state_next = chess_pkg::idle;
      end
      default: begin
        state_next = chess_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= chess_pkg::idle;
      busy  <= 1'b0;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      // one stage late, lines up with the registered plot stream
      busy  <= (state == chess_pkg::load) || (state == chess_pkg::fetch) ||
               (state == chess_pkg::draw);
      done  <= (state == chess_pkg::finish);
    end
  end

  assign d.clear_frame = (state == chess_pkg::idle) && start;  // frame entry
  assign d.load_square = (state == chess_pkg::load);
  assign d.count_en    = (state == chess_pkg::draw);

endmodule

// File: source/draw_if.sv
/* draw control to datapath link */

`timescale 1ns/1ps

interface draw_if;

  logic       load_square;  // advance to next square
  logic       count_en;     // step pixel counters
  logic       clear_frame;  // start of a new frame
  logic [2:0] view_x;
  logic [2:0] view_y;
  logic [4:0] count_x;
  logic [4:0] count_y;
  logic       square_done;  // last pixel of current square
  logic       last_square;  // square (7,7)

  modport ctrl (
    output load_square, count_en, clear_frame,
    input  square_done, last_square
  );

  modport walker (
    input  load_square, count_en, clear_frame,
    output view_x, view_y, count_x, count_y, square_done, last_square
  );

  modport shade (
    input view_x, view_y, count_x, count_y, count_en
  );

endinterface

// File: source/pixel_shader.sv
/* per pixel colour selection */

`timescale 1ns/1ps

module pixel_shader (
  input  logic                     clk,
  input  logic                     resetn,
  draw_if.shade                    d,
  input  chess_pkg::piece_t        piece,
  input  logic [2:0]               cursor_x,
  input  logic [2:0]               cursor_y,
  input  logic                     select,
  input  logic [8:0]               x_pos,
  input  logic [7:0]               y_pos,
  output logic                     plot,
  output logic [8:0]               x_out,
  output logic [7:0]               y_out,
  output chess_pkg::pixel_colour_t colour
);

  localparam logic [4:0] edge_hi = 5'(chess_pkg::square_pix - 1);
  localparam logic [4:0] arm_lo  = 5'(chess_pkg::mark_len);
  localparam logic [4:0] arm_hi  = 5'(chess_pkg::square_pix - 1 - chess_pkg::mark_len);

  logic [4:0] inset;       // glyph box margin, shrinks with kind
  logic [4:0] box_hi;
  logic       on_cursor;
  logic       on_bracket;
  logic       in_glyph;
  chess_pkg::pixel_colour_t colour_next;

  assign inset  = 5'd13 - {1'b0, piece.kind, 1'b0};
  assign box_hi = edge_hi - inset;

  assign on_cursor  = select && (d.view_x == cursor_x) && (d.view_y == cursor_y);
  assign on_bracket = ((d.count_y == 5'd0 || d.count_y == edge_hi) &&
                       (d.count_x < arm_lo || d.count_x > arm_hi)) ||
                      ((d.count_x == 5'd0 || d.count_x == edge_hi) &&
                       (d.count_y < arm_lo || d.count_y > arm_hi));
  assign in_glyph   = (piece.kind != chess_pkg::none) &&
                      (d.count_x >= inset) && (d.count_x <= box_hi) &&
                      (d.count_y >= inset) && (d.count_y <= box_hi);

  always_comb begin
    if (on_cursor && on_bracket)
      colour_next = chess_pkg::marker;  // marker beats everything
    else if (in_glyph)
      colour_next = piece.black ? chess_pkg::black_piece : chess_pkg::white_piece;
    else if (d.view_x[0] == d.view_y[0])
      colour_next = chess_pkg::light_square;  // even parity
    else
      colour_next = chess_pkg::dark_square;
  end

  always_ff @(posedge clk) begin
    if (!resetn)
      plot <= 1'b0;
    else
      plot <= d.count_en;
  end

  // pixel payload, qualified by plot
  always_ff @(posedge clk) begin
    x_out  <= x_pos;
    y_out  <= y_pos;
    colour <= colour_next;
  end

endmodule

// File: source/square_walker.sv
/* square and pixel position counters */

`timescale 1ns/1ps

module square_walker (
  input  logic       clk,
  input  logic       resetn,
  draw_if.walker     d,
  output logic [8:0] x_pos,
  output logic [7:0] y_pos
);

  localparam logic [4:0] count_last = 5'(chess_pkg::square_pix - 1);
  localparam logic [2:0] view_last  = 3'(chess_pkg::board_n - 1);

  logic [8:0] base_x;       // left edge of current square
  logic [7:0] base_y;       // top edge of current square
  logic       first_square; // first load of a frame keeps (0,0)

  always_ff @(posedge clk) begin
    if (!resetn) begin
      d.view_x     <= 3'd0;
      d.view_y     <= 3'd0;
      d.count_x    <= 5'd0;
      d.count_y    <= 5'd0;
      base_x       <= 9'(chess_pkg::origin_x);
      base_y       <= 8'(chess_pkg::origin_y);
      first_square <= 1'b1;
    end else if (d.clear_frame) begin
      d.view_x     <= 3'd0;
      d.view_y     <= 3'd0;
      d.count_x    <= 5'd0;
      d.count_y    <= 5'd0;
      base_x       <= 9'(chess_pkg::origin_x);
      base_y       <= 8'(chess_pkg::origin_y);
      first_square <= 1'b1;
    end else begin
      if (d.load_square) begin
        if (first_square) begin
          first_square <= 1'b0;
        end else if (d.view_x == view_last) begin
          d.view_x <= 3'd0;  // wrap to next row
          d.view_y <= d.view_y + 3'd1;
          base_x   <= 9'(chess_pkg::origin_x);
          base_y   <= base_y + 8'(chess_pkg::square_pix);
        end else begin
          d.view_x <= d.view_x + 3'd1;
          base_x   <= base_x + 9'(chess_pkg::square_pix);
        end
      end
      if (d.count_en) begin
        if (d.count_x == count_last) begin
          d.count_x <= 5'd0;
          d.count_y <= (d.count_y == count_last) ? 5'd0 : d.count_y + 5'd1;
        end else begin
          d.count_x <= d.count_x + 5'd1;
        end
      end
    end
  end

  assign d.square_done = (d.count_x == count_last) && (d.count_y == count_last);
  assign d.last_square = (d.view_x == view_last) && (d.view_y == view_last);

  assign x_pos = base_x + 9'(d.count_x);
  assign y_pos = base_y + 8'(d.count_y);

endmodule

// File: tb/chess_board_view_properties.sv
/* chess board view output checks */

`timescale 1ns/1ps

module chess_board_view_properties (
  input logic       clk,
  input logic       resetn,
  input logic       plot,
  input logic       busy,
  input logic       done,
  input logic [8:0] x_out,
  input logic [7:0] y_out
);

  // pixels only stream inside a frame
  plot_in_frame: assert property (@(posedge clk) disable iff (!resetn) plot |-> busy)
    else $error("plot high while busy is low");

  done_pulse: assert property (@(posedge clk) disable iff (!resetn) done |=> !done)
    else $error("done held longer than one cycle");

  done_idle: assert property (@(posedge clk) disable iff (!resetn)
                              done |-> !busy ##1 !busy)
    else $error("busy not low around done");

  coord_range: assert property (@(posedge clk) disable iff (!resetn)
    plot |-> (x_out >= 9'(chess_pkg::origin_x)) &&
             (x_out <= 9'(chess_pkg::origin_x + chess_pkg::board_n * chess_pkg::square_pix - 1)) &&
             (y_out >= 8'(chess_pkg::origin_y)) &&
             (y_out <= 8'(chess_pkg::origin_y + chess_pkg::board_n * chess_pkg::square_pix - 1)))
    else $error("plotted pixel outside the board");

  // synchronous reset, outputs clear one edge later
  reset_quiet: assert property (@(posedge clk) !resetn |=> (!busy && !plot && !done))
    else $error("outputs active during reset");

endmodule

bind chess_board_view chess_board_view_properties u_props (
  .clk    (clk),
  .resetn (resetn),
  .plot   (plot),
  .busy   (busy),
  .done   (done),
  .x_out  (x_out),
  .y_out  (y_out)
);

// File: tb/chess_board_view_tb.sv
/* chess board view testbench */

`timescale 1ns/1ps

module chess_board_view_tb;

  logic                     clk;
  logic                     resetn;
  logic                     start;
  logic                     select;
  logic [2:0]               cursor_x;
  logic [2:0]               cursor_y;
  logic                     wr_en;
  logic [2:0]               wr_x;
  logic [2:0]               wr_y;
  chess_pkg::piece_t        wr_piece;
  logic                     plot;
  logic [8:0]               x_out;
  logic [7:0]               y_out;
  chess_pkg::pixel_colour_t colour;
  logic                     busy;
  logic                     done;

  chess_pkg::piece_t ref_board [64];  // row * 8 + column
  bit ref_select;
  int ref_cursor_x;
  int ref_cursor_y;
  int errors;
  int pix_count;   // plots seen in the current frame
  int mark_count;
  int done_count;
  int starts;
  int pixels_checked;
  bit hung;

  chess_board_view UUT (
    .clk      (clk),
    .resetn   (resetn),
    .start    (start),
    .select   (select),
    .cursor_x (cursor_x),
    .cursor_y (cursor_y),
    .wr_en    (wr_en),
    .wr_x     (wr_x),
    .wr_y     (wr_y),
    .wr_piece (wr_piece),
    .plot     (plot),
    .x_out    (x_out),
    .y_out    (y_out),
    .colour   (colour),
    .busy     (busy),
    .done     (done)
  );

  always #5 clk = ~clk;

  function automatic int frame_pixels();
    return chess_pkg::board_n * chess_pkg::board_n *
           chess_pkg::square_pix * chess_pkg::square_pix;
  endfunction

  // derives square and offset from the screen position before the priority rules
  function automatic chess_pkg::pixel_colour_t expected_colour(int x, int y);
    int sq_x;
    int sq_y;
    int cx;
    int cy;
    int inset;
    int last;
    bit bracket;
    chess_pkg::piece_t p;
    last    = chess_pkg::square_pix - 1;
    sq_x    = (x - chess_pkg::origin_x) / chess_pkg::square_pix;
    cx      = (x - chess_pkg::origin_x) % chess_pkg::square_pix;
    sq_y    = (y - chess_pkg::origin_y) / chess_pkg::square_pix;
    cy      = (y - chess_pkg::origin_y) % chess_pkg::square_pix;
    p       = ref_board[sq_y * chess_pkg::board_n + sq_x];
    inset   = 13 - 2 * int'(p.kind);
    bracket = ((cy == 0 || cy == last) &&
               (cx < chess_pkg::mark_len || cx > last - chess_pkg::mark_len)) ||
              ((cx == 0 || cx == last) &&
               (cy < chess_pkg::mark_len || cy > last - chess_pkg::mark_len));
    if (ref_select && sq_x == ref_cursor_x && sq_y == ref_cursor_y && bracket)
      return chess_pkg::marker;
    if (p.kind != chess_pkg::none && cx >= inset && cx <= last - inset &&
        cy >= inset && cy <= last - inset)
      return p.black ? chess_pkg::black_piece : chess_pkg::white_piece;
    if ((sq_x + sq_y) % 2 == 0)
      return chess_pkg::light_square;
    return chess_pkg::dark_square;
  endfunction

  function automatic chess_pkg::piece_t random_piece();
    chess_pkg::piece_t p;
    p.black = 1'($urandom_range(0, 1));
    p.kind  = chess_pkg::piece_kind_t'(3'($urandom_range(0, 6)));
    return p;
  endfunction

  task automatic check_colour(chess_pkg::pixel_colour_t got, chess_pkg::pixel_colour_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: colour got %s expected %s", $time, got.name(), exp.name());
    end
  endtask

  task automatic check_coord(logic [8:0] got_x, logic [7:0] got_y,
                             logic [8:0] exp_x, logic [7:0] exp_y);
    if (got_x !== exp_x) begin
      errors++;
      $display("FAIL at %0t: x_out got %0d expected %0d", $time, got_x, exp_x);
    end
    if (got_y !== exp_y) begin
      errors++;
      $display("FAIL at %0t: y_out got %0d expected %0d", $time, got_y, exp_y);
    end
  endtask

  task automatic check_count(string what, int got, int exp);
    if (got != exp) begin
      errors++;
      $display("FAIL at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // compares every plotted pixel at the falling edge where outputs are stable
  always @(negedge clk) begin : pixel_compare
    int sq;
    int off;
    logic [8:0] exp_x;
    logic [7:0] exp_y;
    if (resetn && plot) begin
      if (pix_count < frame_pixels()) begin
        sq    = pix_count / (chess_pkg::square_pix * chess_pkg::square_pix);
        off   = pix_count % (chess_pkg::square_pix * chess_pkg::square_pix);
        exp_x = 9'(chess_pkg::origin_x + chess_pkg::square_pix * (sq % chess_pkg::board_n) +
                   off % chess_pkg::square_pix);
        exp_y = 8'(chess_pkg::origin_y + chess_pkg::square_pix * (sq / chess_pkg::board_n) +
                   off / chess_pkg::square_pix);
        check_coord(x_out, y_out, exp_x, exp_y);
        check_colour(colour, expected_colour(int'(exp_x), int'(exp_y)));
      end
      if (colour == chess_pkg::marker)
        mark_count++;
      pix_count++;
      pixels_checked++;
    end
    if (resetn && done) begin
      check_count("plots per frame", pix_count, frame_pixels());
      check_count("marker pixels", mark_count,
                  ref_select ? 4 * (2 * chess_pkg::mark_len - 1) : 0);  // 7 per corner
      done_count++;
      pix_count  = 0;
      mark_count = 0;
    end
  end

  task automatic write_square(int x, int y, chess_pkg::piece_t p);
    @(posedge clk);
    wr_en    <= 1'b1;
    wr_x     <= 3'(x);
    wr_y     <= 3'(y);
    wr_piece <= p;
    ref_board[y * chess_pkg::board_n + x] = p;
  endtask

  task automatic end_writes();
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic set_view(bit sel, logic [2:0] cx, logic [2:0] cy);
    @(posedge clk);
    select       <= sel;
    cursor_x     <= cx;
    cursor_y     <= cy;
    ref_select   = sel;
    ref_cursor_x = int'(cx);
    ref_cursor_y = int'(cy);
  endtask

  task automatic wait_done();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < 2 * frame_pixels(); i++) begin
      @(negedge clk);
      if (done) begin
        seen = 1'b1;
        break;
      end
    end
    if (!seen) begin
      errors++;
      hung = 1'b1;
      $display("timeout at %0t: done never arrived after start", $time);
    end
  endtask

  // poke_busy sends a second start in the middle of the frame
  task automatic run_frame(bit poke_busy);
    bit extra;
    extra = 1'b0;
    if (!hung) begin
      starts++;
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      if (poke_busy) begin
        repeat (100) @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
      end
      wait_done();
      repeat (20) begin
        @(negedge clk);
        if (busy)
          extra = 1'b1;
      end
      if (extra) begin
        errors++;
        $display("busy rose again after done, a start during busy was accepted");
      end
      check_count("completed frames", done_count, starts);
    end
  endtask

  initial begin
    chess_pkg::piece_t p;
    void'($urandom(23));
    clk      = 1'b0;
    resetn   = 1'b0;
    start    = 1'b0;
    select   = 1'b0;
    cursor_x = 3'd0;
    cursor_y = 3'd0;
    wr_en    = 1'b0;
    wr_x     = 3'd0;
    wr_y     = 3'd0;
    wr_piece = '0;
    errors = 0;
    pix_count = 0;
    mark_count = 0;
    done_count = 0;
    starts = 0;
    pixels_checked = 0;
    hung = 1'b0;
    ref_select = 1'b0;
    ref_cursor_x = 0;
    ref_cursor_y = 0;
    repeat (4) @(posedge clk);
    resetn <= 1'b1;

    // empty board shows only the checker pattern
    p = '0;
    for (int i = 0; i < 64; i++)
      write_square(i % 8, i / 8, p);
    end_writes();
    set_view(1'b0, 3'd0, 3'd0);
    run_frame(1'b0);

    // every kind on both sides with the cursor parked on a piece and select low
    for (int k = 1; k <= 6; k++) begin
      p.kind  = chess_pkg::piece_kind_t'(3'(k));
      p.black = 1'b0;
      write_square(k - 1, 2, p);
      p.black = 1'b1;
      write_square(k + 1, 5, p);
    end
    end_writes();
    set_view(1'b0, 3'd3, 3'd2);
    run_frame(1'b0);

    // random board with marker
    for (int i = 0; i < 64; i++)
      write_square(i % 8, i / 8, random_piece());
    end_writes();
    set_view(1'b1, 3'($urandom_range(0, 7)), 3'($urandom_range(0, 7)));
    run_frame(1'b0);

    // partial rewrite between frames and an extra start while busy
    for (int i = 0; i < 8; i++)
      write_square(int'($urandom_range(0, 7)), int'($urandom_range(0, 7)), random_piece());
    end_writes();
    set_view(1'b1, 3'($urandom_range(0, 7)), 3'($urandom_range(0, 7)));
    run_frame(1'b1);

    $display("pixels checked %0d, frames %0d, errors %0d", pixels_checked, done_count, errors);
    if (errors == 0 && !hung)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
